/* files.f */
+incdir+include
+incdir+tb
source/aes_pkg.sv
source/aes_ifs.sv
source/aes_wb_regs.sv
source/aes_buffer.sv
source/aes_block_ctrl.sv
source/aes_core.sv
source/aes_accel_top.sv
tb/aes_accel_tb.sv

/* include/aes_defs.svh */
`ifndef AES_DEFS_SVH
`define AES_DEFS_SVH

// bus and datapath word
`define AES_WORD_W 32

// shared word buffer
`define AES_BUF_AW 9
`define AES_BUF_DEPTH 512
`define AES_IN_BASE 0
// output region starts past the 256 input words and one spare slot
`define AES_OUT_BASE 257
`define AES_TERM 32'hDEADBEEF

// wishbone word addresses, buffer below 512
`define AES_WB_AW 10
`define AES_REG_CTRL 512
`define AES_REG_STATUS 513
`define AES_REG_KEY0 516
`define AES_REG_KEY1 517
`define AES_REG_KEY2 518
`define AES_REG_KEY3 519

// aes-128
`define AES_ROUNDS 10

`endif

/* run_sim.sh */
#!/bin/sh
# build and run the testbench with verilator, result taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -j 0 -f files.f \
  --top-module aes_accel_tb > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/Vaes_accel_tb > sim.log 2>&1
cat sim.log
grep -q "sim failed" sim.log && exit 1
grep -q "sim passed" sim.log || exit 1
exit 0

/* source/aes_accel_top.sv */
module aes_accel_top (
  input logic clk_in,
  input logic rst_in,
  input logic cyc,
  input logic stb,
  input logic we,
  input aes_pkg::wb_addr_t adr,
  input aes_pkg::word_t dat_w,
  input aes_pkg::be_t sel,
  output aes_pkg::word_t dat_r,
  output logic ack
);

  logic enable;
  aes_pkg::key_t key;
  logic busy;
  logic complete;

  // buffer ports and core handshake
  aes_mem_if host_mem ();
  aes_mem_if seq_mem ();
  aes_core_if core_bus ();

  // wishbone slave, registers, host buffer port
  aes_wb_regs i_regs (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .cyc(cyc),
    .stb(stb),
    .we(we),
    .adr(adr),
    .dat_w(dat_w),
    .sel(sel),
    .dat_r(dat_r),
    .ack(ack),
    .mem(host_mem.master),
    .enable(enable),
    .key(key),
    .busy(busy),
    .complete(complete)
  );

  aes_buffer i_buffer (
    .clk_in(clk_in),
    .host_port(host_mem.ram),
    .seq_port(seq_mem.ram)
  );

  aes_block_ctrl i_ctrl (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .enable(enable),
    .key(key),
    .mem(seq_mem.master),
    .core(core_bus.host),
    .busy(busy),
    .complete(complete)
  );

  aes_core i_core (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .bus(core_bus.core)
  );

endmodule

/* source/aes_block_ctrl.sv */
`include "aes_defs.svh"

module aes_block_ctrl (
  input logic clk_in,
  input logic rst_in,
  input logic enable,
  input aes_pkg::key_t key,
  aes_mem_if.master mem,
  aes_core_if.host core,
  output logic busy,
  output logic complete
);

  aes_pkg::seq_state_e state_q;
  // words read so far, terminator excluded
  aes_pkg::buf_addr_t rd_cnt_q;
  // ciphertext words written so far
  aes_pkg::buf_addr_t wr_cnt_q;
  aes_pkg::block_t block_q;
  logic [6:0] rd_lsb;
  logic [6:0] wr_lsb;
  aes_pkg::word_t out_word;
  logic is_term;

  assign is_term = (mem.rdata == `AES_TERM);

  // word 0 of a block sits in bits 127:96
  assign rd_lsb = {2'd3 - rd_cnt_q[1:0], 5'd0};
  assign wr_lsb = {2'd3 - wr_cnt_q[1:0], 5'd0};
  assign out_word = core.block_out[wr_lsb +: `AES_WORD_W];

  // core handshake
  assign core.start = (state_q == aes_pkg::START);
  assign core.block_in = block_q;
  assign core.key = key;

  // status
  assign busy = (state_q != aes_pkg::IDLE) && (state_q != aes_pkg::DONE);
  assign complete = (state_q == aes_pkg::DONE);

  // buffer port, reads from input region unless writing back
  always_comb begin
    mem.addr = aes_pkg::buf_addr_t'(`AES_IN_BASE) + rd_cnt_q;
    mem.we = '0;
    mem.wdata = out_word;
    case (state_q)
      aes_pkg::WB_WORD: begin
        mem.addr = aes_pkg::buf_addr_t'(`AES_OUT_BASE) + wr_cnt_q;
        mem.we = '1;
      end
      aes_pkg::WB_TERM: begin
        mem.addr = aes_pkg::buf_addr_t'(`AES_OUT_BASE) + wr_cnt_q;
        mem.we = '1;
        mem.wdata = `AES_TERM;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk_in) begin
    if (rst_in || !enable) begin
      // disabled means abort and clear
      state_q <= aes_pkg::IDLE;
      rd_cnt_q <= '0;
      wr_cnt_q <= '0;
      block_q <= '0;
    end else begin
      case (state_q)
        aes_pkg::IDLE: state_q <= aes_pkg::RD_ISSUE;
        // address out, ram output next cycle, sample on the third
        aes_pkg::RD_ISSUE: state_q <= aes_pkg::RD_WAIT;
        aes_pkg::RD_WAIT: state_q <= aes_pkg::RD_TAKE;
        aes_pkg::RD_TAKE: begin
          if (is_term) begin
            // nothing pending means just the terminator
            if (rd_cnt_q[1:0] == 2'd0) begin
              state_q <= aes_pkg::WB_TERM;
            end else begin
              state_q <= aes_pkg::START;
            end
          end else begin
            block_q[rd_lsb +: `AES_WORD_W] <= mem.rdata;
            rd_cnt_q <= rd_cnt_q + 1'b1;
            if (rd_cnt_q[1:0] == 2'd3) begin
              state_q <= aes_pkg::START;
            end else begin
              state_q <= aes_pkg::RD_ISSUE;
            end
          end
        end
        aes_pkg::START: state_q <= aes_pkg::WAIT_CORE;
        aes_pkg::WAIT_CORE: begin
          // core has latched it, zero for the next block
          block_q <= '0;
          if (core.valid) begin
            state_q <= aes_pkg::WB_WORD;
          end
        end
        aes_pkg::WB_WORD: begin
          wr_cnt_q <= wr_cnt_q + 1'b1;
          // caught up with reads, a partial block ends the stream
          if (wr_cnt_q + 1'b1 == rd_cnt_q) begin
            if (rd_cnt_q[1:0] == 2'd0) begin
              state_q <= aes_pkg::RD_ISSUE;
            end else begin
              state_q <= aes_pkg::WB_TERM;
            end
          end
        end
        aes_pkg::WB_TERM: state_q <= aes_pkg::DONE;
        // hold complete until enable drops
        default: ;
      endcase
    end
  end

  // input region is never overwritten
  a_wr_out_region: assert property (@(posedge clk_in) disable iff (rst_in)
    (|mem.we) |-> (mem.addr >= aes_pkg::buf_addr_t'(`AES_OUT_BASE)));

endmodule

/* source/aes_buffer.sv */
`include "aes_defs.svh"

module aes_buffer (
  input logic clk_in,
  aes_mem_if.ram host_port,
  aes_mem_if.ram seq_port
);

  // shared plaintext and ciphertext words
  aes_pkg::word_t mem_q [0:`AES_BUF_DEPTH-1];

  // both ports in one process
  // host stays off the buffer while a run is busy
  always_ff @(posedge clk_in) begin
    for (int b = 0; b < $bits(aes_pkg::be_t); b++) begin
      if (host_port.we[b]) begin
        mem_q[host_port.addr][8*b +: 8] <= host_port.wdata[8*b +: 8];
      end
      if (seq_port.we[b]) begin
        mem_q[seq_port.addr][8*b +: 8] <= seq_port.wdata[8*b +: 8];
      end
    end
    // registered reads, old data on a same-address write
    host_port.rdata <= mem_q[host_port.addr];
    seq_port.rdata <= mem_q[seq_port.addr];
  end

endmodule

/* source/aes_core.sv */
`include "aes_defs.svh"

module aes_core (
  input logic clk_in,
  input logic rst_in,
  aes_core_if.core bus
);

  aes_pkg::core_state_e state_q;
  aes_pkg::round_t round_q;
  aes_pkg::block_t st_q;
  aes_pkg::key_t rk_q;
  aes_pkg::key_t rk_next;
  // after subbytes and shiftrows
  aes_pkg::block_t sr_sb;
  aes_pkg::block_t mixed;
  aes_pkg::block_t st_next;
  logic last;

  // multiply by x in gf(2^8)
  function automatic logic [7:0] xtime(input logic [7:0] b);
    return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
  endfunction

  function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] p;
    logic [7:0] x;
    p = 8'h00;
    x = a;
    for (int i = 0; i < 8; i++) begin
      if (b[i]) begin
        p = p ^ x;
      end
      x = xtime(x);
    end
    return p;
  endfunction

  // s-box: inverse as a^254, then the affine map
  function automatic logic [7:0] sbox(input logic [7:0] a);
    logic [7:0] p;
    logic [7:0] inv;
    p = a;
    inv = 8'h01;
    for (int i = 0; i < 7; i++) begin
      p = gf_mul(p, p);
      inv = gf_mul(inv, p);
    end
    return inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]} ^
           {inv[4:0], inv[7:5]} ^ {inv[3:0], inv[7:4]} ^ 8'h63;
  endfunction

  // round constant, doubled once per round
  function automatic logic [7:0] rcon(input aes_pkg::round_t r);
    logic [7:0] c;
    c = 8'h01;
    for (int i = 1; i < `AES_ROUNDS; i++) begin
      if (i < r) begin
        c = xtime(c);
      end
    end
    return c;
  endfunction

  assign last = (round_q == aes_pkg::round_t'(`AES_ROUNDS));
  assign bus.block_out = st_q;

  // next round key from the current one
  always_comb begin : key_exp
    aes_pkg::word_t t;
    // rotword of w3
    t = {rk_q[23:0], rk_q[31:24]};
    t = {sbox(t[31:24]), sbox(t[23:16]), sbox(t[15:8]), sbox(t[7:0])} ^ {rcon(round_q), 24'h0};
    rk_next[127:96] = rk_q[127:96] ^ t;
    rk_next[95:64] = rk_q[95:64] ^ rk_next[127:96];
    rk_next[63:32] = rk_q[63:32] ^ rk_next[95:64];
    rk_next[31:0] = rk_q[31:0] ^ rk_next[63:32];
  end

  // one full round
  always_comb begin : round_path
    logic [7:0] a0;
    logic [7:0] a1;
    logic [7:0] a2;
    logic [7:0] a3;
    // row r of column c takes the byte of column c+r
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        sr_sb[127-32*c-8*r -: 8] = sbox(st_q[127-32*((c+r)%4)-8*r -: 8]);
      end
    end
    for (int c = 0; c < 4; c++) begin
      a0 = sr_sb[127-32*c -: 8];
      a1 = sr_sb[119-32*c -: 8];
      a2 = sr_sb[111-32*c -: 8];
      a3 = sr_sb[103-32*c -: 8];
      mixed[127-32*c -: 8] = xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3;
      mixed[119-32*c -: 8] = a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3;
      mixed[111-32*c -: 8] = a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3;
      mixed[103-32*c -: 8] = xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3);
    end
    // final round skips mixcolumns
    st_next = (last ? sr_sb : mixed) ^ rk_next;
  end

  // control, valid one cycle after round 10
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state_q <= aes_pkg::C_IDLE;
      round_q <= '0;
      bus.valid <= 1'b0;
    end else begin
      bus.valid <= 1'b0;
      case (state_q)
        aes_pkg::C_IDLE: begin
          if (bus.start) begin
            state_q <= aes_pkg::C_RUN;
            round_q <= 4'd1;
          end
        end
        aes_pkg::C_RUN: begin
          if (last) begin
            state_q <= aes_pkg::C_IDLE;
            bus.valid <= 1'b1;
          end else begin
            round_q <= round_q + 1'b1;
          end
        end
        default: state_q <= aes_pkg::C_IDLE;
      endcase
    end
  end

  // state and round key, initial addroundkey on start
  always_ff @(posedge clk_in) begin
    if (state_q == aes_pkg::C_IDLE && bus.start) begin
      st_q <= bus.block_in ^ bus.key;
      rk_q <= bus.key;
    end else if (state_q == aes_pkg::C_RUN) begin
      st_q <= st_next;
      rk_q <= rk_next;
    end
  end

  // sequencer waits for valid before the next start
  a_no_start_busy: assert property (@(posedge clk_in) disable iff (rst_in)
    bus.start |-> (state_q == aes_pkg::C_IDLE));

endmodule

/* source/aes_ifs.sv */
// one port of the word buffer
// rdata follows addr by one cycle, writes land at the edge
interface aes_mem_if;

  aes_pkg::buf_addr_t addr;
  aes_pkg::be_t we;
  aes_pkg::word_t wdata;
  aes_pkg::word_t rdata;

  modport master (
    output addr,
    output we,
    output wdata,
    input rdata
  );

  modport ram (
    input addr,
    input we,
    input wdata,
    output rdata
  );

endinterface

// sequencer to cipher core handshake
// start is a single pulse, valid pulses once per block
interface aes_core_if;

  logic start;
  aes_pkg::block_t block_in;
  aes_pkg::key_t key;
  aes_pkg::block_t block_out;
  logic valid;

  modport host (output start, output block_in, output key, input block_out, input valid);
  modport core (input start, input block_in, input key, output block_out, output valid);

endinterface

/* source/aes_pkg.sv */
`include "aes_defs.svh"

package aes_pkg;

  // data and address widths
  typedef logic [`AES_WORD_W-1:0] word_t;
  typedef logic [`AES_BUF_AW-1:0] buf_addr_t;
  typedef logic [`AES_WB_AW-1:0] wb_addr_t;
  typedef logic [`AES_WORD_W/8-1:0] be_t;

  // cipher state, key and round index
  typedef logic [4*`AES_WORD_W-1:0] block_t;
  typedef logic [4*`AES_WORD_W-1:0] key_t;
  typedef logic [3:0] round_t;

  // block sequencer
  typedef enum logic [3:0] {
    RD_ISSUE, RD_WAIT, RD_TAKE, START, WAIT_CORE, WB_WORD, WB_TERM, DONE, IDLE
  } seq_state_e;

  // cipher core
  typedef enum logic {
    C_IDLE, C_RUN
  } core_state_e;

endpackage

/* source/aes_wb_regs.sv */
`include "aes_defs.svh"

module aes_wb_regs (
  input logic clk_in,
  input logic rst_in,
  input logic cyc,
  input logic stb,
  input logic we,
  input aes_pkg::wb_addr_t adr,
  input aes_pkg::word_t dat_w,
  input aes_pkg::be_t sel,
  output aes_pkg::word_t dat_r,
  output logic ack,
  aes_mem_if.master mem,
  output logic enable,
  output aes_pkg::key_t key,
  input logic busy,
  input logic complete
);

  logic req;
  logic is_buf;
  logic rd_pend;
  aes_pkg::word_t reg_rdata;

  // fresh request, not one already acked or in flight
  assign req = cyc && stb && !ack && !rd_pend;
  assign is_buf = (adr < aes_pkg::wb_addr_t'(`AES_BUF_DEPTH));

  // buffer sees the bus address right away
  assign mem.addr = adr[`AES_BUF_AW-1:0];
  assign mem.wdata = dat_w;
  // single write per request, sel gives the bytes
  assign mem.we = (req && we && is_buf) ? sel : '0;

  // register read mux
  always_comb begin
    case (adr)
      aes_pkg::wb_addr_t'(`AES_REG_CTRL): reg_rdata = {{(`AES_WORD_W-1){1'b0}}, enable};
      aes_pkg::wb_addr_t'(`AES_REG_STATUS): reg_rdata = {{(`AES_WORD_W-2){1'b0}}, busy, complete};
      aes_pkg::wb_addr_t'(`AES_REG_KEY0): reg_rdata = key[127:96];
      aes_pkg::wb_addr_t'(`AES_REG_KEY1): reg_rdata = key[95:64];
      aes_pkg::wb_addr_t'(`AES_REG_KEY2): reg_rdata = key[63:32];
      aes_pkg::wb_addr_t'(`AES_REG_KEY3): reg_rdata = key[31:0];
      default: reg_rdata = '0;
    endcase
  end

  // ack, pending buffer read, control and key registers
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      ack <= 1'b0;
      rd_pend <= 1'b0;
      enable <= 1'b0;
      key <= '0;
    end else begin
      ack <= 1'b0;
      rd_pend <= 1'b0;
      if (rd_pend) begin
        // ram data is ready now, drop the ack if the master gave up
        ack <= cyc && stb;
      end else if (req) begin
        if (is_buf && !we) begin
          rd_pend <= 1'b1;
        end else begin
          ack <= 1'b1;
        end
        if (!is_buf && we) begin
          case (adr)
            aes_pkg::wb_addr_t'(`AES_REG_CTRL): enable <= dat_w[0];
            aes_pkg::wb_addr_t'(`AES_REG_KEY0): key[127:96] <= dat_w;
            aes_pkg::wb_addr_t'(`AES_REG_KEY1): key[95:64] <= dat_w;
            aes_pkg::wb_addr_t'(`AES_REG_KEY2): key[63:32] <= dat_w;
            aes_pkg::wb_addr_t'(`AES_REG_KEY3): key[31:0] <= dat_w;
            default: ;
          endcase
        end
      end
    end
  end

  // read data goes out together with ack
  always_ff @(posedge clk_in) begin
    if (rd_pend) begin
      dat_r <= mem.rdata;
    end else if (req && !we) begin
      dat_r <= reg_rdata;
    end
  end

  // classic slave, no ack outside a request
  a_ack_in_cycle: assert property (@(posedge clk_in) disable iff (rst_in)
    ack |-> (cyc && stb));

endmodule

/* tb/aes_tb_tasks.svh */
`ifndef AES_TB_TASKS_SVH
`define AES_TB_TASKS_SVH

// fips-197 vectors
localparam aes_pkg::key_t C1_KEY = 128'h000102030405060708090a0b0c0d0e0f;
localparam aes_pkg::block_t C1_PT = 128'h00112233445566778899aabbccddeeff;
localparam aes_pkg::block_t C1_CT = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
localparam aes_pkg::key_t B_KEY = 128'h2b7e151628aed2a6abf7158809cf4f3c;
localparam aes_pkg::block_t B_PT = 128'h3243f6a8885a308d313198a2e0370734;
localparam aes_pkg::block_t B_CT = 128'h3925841d02dc09fbdc118597196a0b32;

// one classic single access, called and left just after a rising edge
task automatic bus_access(input logic wr, input int a, input aes_pkg::word_t d,
                          output aes_pkg::word_t q);
  int waited;
  waited = 0;
  cyc = 1'b1;
  stb = 1'b1;
  we = wr;
  adr = aes_pkg::wb_addr_t'(a);
  dat_w = d;
  sel = '1;
  // ack after one edge for registers and writes, two for buffer reads
  do begin
    @(posedge clk_in);
    #1;
    waited++;
  end while (!ack && waited < ACK_TIMEOUT);
  assert (ack) else begin
    $display("no ack for bus access to address %0d", a);
    err_cnt++;
  end
  q = dat_r;
  // hold the request through the edge that samples ack
  @(posedge clk_in);
  #1;
  cyc = 1'b0;
  stb = 1'b0;
  we = 1'b0;
endtask

task automatic wb_write(input int a, input aes_pkg::word_t d);
  aes_pkg::word_t unused;
  bus_access(1'b1, a, d, unused);
endtask

task automatic wb_read(input int a, output aes_pkg::word_t q);
  bus_access(1'b0, a, '0, q);
endtask

task automatic check_word(input string name, input aes_pkg::word_t got,
                          input aes_pkg::word_t exp);
  check_cnt++;
  assert (got == exp) else begin
    $display("mismatch %s: got %h, expected %h", name, got, exp);
    err_cnt++;
  end
endtask

task automatic check_reg(input string name, input int a, input aes_pkg::word_t exp);
  aes_pkg::word_t got;
  wb_read(a, got);
  check_word(name, got, exp);
endtask

task automatic check_buf(input int a, input aes_pkg::word_t exp);
  aes_pkg::word_t got;
  wb_read(a, got);
  check_word($sformatf("dat_r (buffer word %0d)", a), got, exp);
endtask

// four words, first word is bits 127:96
task automatic check_block(input int a, input aes_pkg::block_t exp);
  for (int i = 0; i < 4; i++) begin
    check_buf(a + i, exp[127-32*i -: 32]);
  end
endtask

// only that something landed, value not known here
task automatic check_written(input int a);
  aes_pkg::word_t got;
  wb_read(a, got);
  check_cnt++;
  assert (got != '0) else begin
    $display("buffer word %0d was not written by the sequencer", a);
    err_cnt++;
  end
endtask

task automatic load_key(input aes_pkg::key_t k);
  wb_write(`AES_REG_KEY0, k[127:96]);
  wb_write(`AES_REG_KEY1, k[95:64]);
  wb_write(`AES_REG_KEY2, k[63:32]);
  wb_write(`AES_REG_KEY3, k[31:0]);
endtask

task automatic push_block(input aes_pkg::block_t b);
  for (int i = 0; i < 4; i++) begin
    stream_q.push_back(b[127-32*i -: 32]);
  end
endtask

task automatic clear_output(input int n);
  for (int i = 0; i < n; i++) begin
    wb_write(`AES_OUT_BASE + i, '0);
  end
endtask

// poll status until complete
task automatic wait_complete();
  aes_pkg::word_t st;
  int polls;
  st = '0;
  polls = 0;
  while (!st[0] && polls < POLL_TIMEOUT) begin
    wb_read(`AES_REG_STATUS, st);
    polls++;
  end
  check_cnt++;
  assert (st[0]) else begin
    $display("complete not seen after %0d status polls", polls);
    err_cnt++;
  end
endtask

// stream into the input region, enable, wait for the end
task automatic run_stream();
  wb_write(`AES_REG_CTRL, 32'h0);
  for (int i = 0; i < stream_q.size(); i++) begin
    wb_write(`AES_IN_BASE + i, stream_q[i]);
  end
  wb_write(`AES_REG_CTRL, 32'h1);
  wait_complete();
endtask

task automatic begin_test();
  test_err_base = err_cnt;
  stream_q.delete();
endtask

task automatic end_test(input string name);
  int errs;
  errs = err_cnt - test_err_base;
  test_cnt++;
  if (errs != 0) begin
    fail_cnt++;
    $display("test %s: FAILED with %0d errors", name, errs);
  end else begin
    $display("test %s: ok", name);
  end
endtask

task automatic test_reset_regs();
  begin_test();
  check_reg("status", `AES_REG_STATUS, 32'h0);
  load_key(128'h01234567_89abcdef_fedcba98_76543210);
  check_reg("key0", `AES_REG_KEY0, 32'h01234567);
  check_reg("key1", `AES_REG_KEY1, 32'h89abcdef);
  check_reg("key2", `AES_REG_KEY2, 32'hfedcba98);
  check_reg("key3", `AES_REG_KEY3, 32'h76543210);
  // terminator first so the enabled run stays harmless
  wb_write(`AES_IN_BASE, `AES_TERM);
  wb_write(`AES_REG_CTRL, 32'h1);
  check_reg("ctrl", `AES_REG_CTRL, 32'h1);
  wb_write(`AES_REG_CTRL, 32'h0);
  check_reg("ctrl", `AES_REG_CTRL, 32'h0);
  end_test("reset_regs");
endtask

task automatic test_single_block();
  begin_test();
  load_key(C1_KEY);
  push_block(C1_PT);
  stream_q.push_back(`AES_TERM);
  run_stream();
  check_block(`AES_OUT_BASE, C1_CT);
  check_buf(`AES_OUT_BASE + 4, `AES_TERM);
  wb_write(`AES_REG_CTRL, 32'h0);
  end_test("single_block");
endtask

task automatic test_two_blocks();
  begin_test();
  load_key(B_KEY);
  push_block(B_PT);
  push_block(B_PT);
  stream_q.push_back(`AES_TERM);
  run_stream();
  // ecb, same plaintext gives the same ciphertext
  check_block(`AES_OUT_BASE, B_CT);
  check_block(`AES_OUT_BASE + 4, B_CT);
  check_buf(`AES_OUT_BASE + 8, `AES_TERM);
  wb_write(`AES_REG_CTRL, 32'h0);
  end_test("two_blocks");
endtask

task automatic test_partial_empty();
  begin_test();
  // partial block, output cut to two words
  wb_write(`AES_REG_CTRL, 32'h0);
  clear_output(9);
  stream_q.push_back(B_PT[127:96]);
  stream_q.push_back(B_PT[95:64]);
  stream_q.push_back(`AES_TERM);
  run_stream();
  check_written(`AES_OUT_BASE);
  check_written(`AES_OUT_BASE + 1);
  check_buf(`AES_OUT_BASE + 2, `AES_TERM);
  check_buf(`AES_OUT_BASE + 3, 32'h0);
  // empty stream, terminator only
  wb_write(`AES_REG_CTRL, 32'h0);
  clear_output(2);
  stream_q.delete();
  stream_q.push_back(`AES_TERM);
  run_stream();
  check_buf(`AES_OUT_BASE, `AES_TERM);
  check_buf(`AES_OUT_BASE + 1, 32'h0);
  wb_write(`AES_REG_CTRL, 32'h0);
  end_test("partial_empty");
endtask

task automatic test_enable_ctrl();
  begin_test();
  load_key(C1_KEY);
  wb_write(`AES_REG_CTRL, 32'h0);
  clear_output(5);
  push_block(C1_PT);
  stream_q.push_back(`AES_TERM);
  for (int i = 0; i < stream_q.size(); i++) begin
    wb_write(`AES_IN_BASE + i, stream_q[i]);
  end
  // still reading the first block, busy only
  wb_write(`AES_REG_CTRL, 32'h1);
  check_reg("status", `AES_REG_STATUS, 32'h2);
  // abort mid run
  wb_write(`AES_REG_CTRL, 32'h0);
  check_reg("status", `AES_REG_STATUS, 32'h0);
  // rerun over the same input
  wb_write(`AES_REG_CTRL, 32'h1);
  wait_complete();
  check_block(`AES_OUT_BASE, C1_CT);
  check_buf(`AES_OUT_BASE + 4, `AES_TERM);
  // dropping enable clears complete too
  wb_write(`AES_REG_CTRL, 32'h0);
  check_reg("status", `AES_REG_STATUS, 32'h0);
  end_test("enable_ctrl");
endtask

`endif

/* tb/aes_accel_tb.sv */
`include "aes_defs.svh"

module aes_accel_tb;

  // bounds for every wait loop
  localparam int ACK_TIMEOUT = 20;
  localparam int POLL_TIMEOUT = 300;

  logic clk_in;
  logic rst_in;
  logic cyc;
  logic stb;
  logic we;
  aes_pkg::wb_addr_t adr;
  aes_pkg::word_t dat_w;
  aes_pkg::be_t sel;
  aes_pkg::word_t dat_r;
  logic ack;

  // bookkeeping
  int err_cnt;
  int check_cnt;
  int test_cnt;
  int fail_cnt;
  int test_err_base;

  // plaintext stream for the next run
  aes_pkg::word_t stream_q[$];

  aes_accel_top i_dut (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .cyc(cyc),
    .stb(stb),
    .we(we),
    .adr(adr),
    .dat_w(dat_w),
    .sel(sel),
    .dat_r(dat_r),
    .ack(ack)
  );

  // 100 unit period
  always begin
    #50 clk_in = ~clk_in;
  end

  `include "aes_tb_tasks.svh"

  initial begin
    clk_in = 1'b0;
    rst_in = 1'b1;
    cyc = 1'b0;
    stb = 1'b0;
    we = 1'b0;
    adr = '0;
    dat_w = '0;
    sel = '0;
    err_cnt = 0;
    check_cnt = 0;
    test_cnt = 0;
    fail_cnt = 0;
    test_err_base = 0;
    // reset over ten rising edges, release just after the last
    repeat (10) @(posedge clk_in);
    #1;
    rst_in = 1'b0;
    test_reset_regs();
    test_single_block();
    test_two_blocks();
    test_partial_empty();
    test_enable_ctrl();
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             test_cnt, fail_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule
